//--- hl_ctrl_macros.svh
`ifndef HL_CTRL_MACROS_SVH
`define HL_CTRL_MACROS_SVH

// Command path widths
`define HL_CMD_ADDR_W 6
`define HL_CMD_DATA_W 32
`define HL_RESP_W 40

// Bits in one AD9866 serial write
`define HL_SPI_W 16

// Register addresses
`define HL_REG_TX_CTRL 6'h0A
`define HL_REG_AD9866_SPI 6'h3B

// Timing counts in clk_ctrl cycles
`define HL_TX_HANG_CYCLES 64
`define HL_RST_RELEASE_CYCLES 32
`define HL_SYNC_STAGES 2

// Response word layout
`define HL_RESP_ADDR_LSB 34
`define HL_RESP_TXON_BIT 33
`define HL_RESP_HANG_BIT 32
`define HL_RESP_CLIP_BIT 0
`define HL_RESP_GOOD_BIT 1
`define HL_RESP_SPEED_LSB 2
`define HL_RESP_HAVEIP_BIT 4
`define HL_RESP_BUSY_BIT 5

`endif

//--- hl_ctrl_pkg.sv
`include "hl_ctrl_macros.svh"

package hl_ctrl_pkg;

  ////////////////////////////////////////
  // Host command
  ////////////////////////////////////////

  // 40 bits, address in the top bits
  typedef struct packed {
    logic [`HL_CMD_ADDR_W-1:0] addr;
    logic [`HL_CMD_DATA_W-1:0] data;
    logic                      ptt;
    logic                      requires_resp;
  } cmd_t;

  ////////////////////////////////////////
  // Status from the other domains
  ////////////////////////////////////////

  // Receive level flags from the ADC side
  typedef struct packed {
    logic clip;
    logic goodlvl;
  } rx_flags_t;

  // Link summary from the network side
  typedef struct packed {
    logic       dhcp;
    logic       fixedip;
    logic [1:0] speed;
  } net_state_t;

endpackage

//--- level_sync.sv
`timescale 1ns/1ns
`include "hl_ctrl_macros.svh"

module level_sync #(
  parameter type T = hl_ctrl_pkg::rx_flags_t,
  parameter int STAGES = `HL_SYNC_STAGES
) (
  input  logic clk_ctrl,
  input  logic rst_n_i,
  input  T     d_i,
  output T     q_o
);

  // Synchronizer chain, last entry is the usable sample
  T sync_q [STAGES];
  // Previous synchronized sample for the stability check
  T prev_q;

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      for (int i = 0; i < STAGES; i++) begin
        sync_q[i] <= '0;
      end
      prev_q <= '0;
      q_o    <= '0;
    end else begin
      sync_q[0] <= d_i;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      prev_q <= sync_q[STAGES-1];
      // Bits may land on different cycles, pass only a settled value
      if (sync_q[STAGES-1] == prev_q) begin
        q_o <= prev_q;
      end
    end
  end

endmodule

//--- cmd_capture.sv
`timescale 1ns/1ns
`include "hl_ctrl_macros.svh"

module cmd_capture (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  logic                      cmd_cnt_i,
  input  logic                      cmd_ptt_i,
  input  logic                      cmd_resp_i,
  input  logic [`HL_CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [`HL_CMD_DATA_W-1:0] cmd_data_i,
  output logic                      cmd_rqst_o,
  output hl_ctrl_pkg::cmd_t         cmd_o
);

  localparam int MSB = `HL_SYNC_STAGES - 1;

  logic [MSB:0] cnt_sync_q;
  logic         cnt_prev_q;
  logic         cnt_edge;

  // Any change of the synchronized count is a new command
  assign cnt_edge = cnt_sync_q[MSB] ^ cnt_prev_q;

  ////////////////////////////////////////
  // Toggle synchronizer and edge detect
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      cnt_sync_q <= '0;
      cnt_prev_q <= 1'b0;
      cmd_rqst_o <= 1'b0;
    end else begin
      cnt_sync_q <= {cnt_sync_q[MSB-1:0], cmd_cnt_i};
      cnt_prev_q <= cnt_sync_q[MSB];
      cmd_rqst_o <= cnt_edge;
    end
  end

  ////////////////////////////////////////
  // Field capture
  ////////////////////////////////////////

  // Fields settle before the count toggles, safe to take them here
  always_ff @(posedge clk_ctrl) begin
    if (cnt_edge) begin
      cmd_o.addr          <= cmd_addr_i;
      cmd_o.data          <= cmd_data_i;
      cmd_o.ptt           <= cmd_ptt_i;
      cmd_o.requires_resp <= cmd_resp_i;
    end
  end

endmodule

//--- ad9866_spi.sv
`timescale 1ns/1ns
`include "hl_ctrl_macros.svh"

module ad9866_spi (
  input  logic                 clk_ctrl,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  logic [`HL_SPI_W-1:0] word_i,
  output logic                 busy_o,
  output logic                 sen_n_o,
  output logic                 sclk_o,
  output logic                 sdio_o,
  output logic                 ad9866_rst_n_o
);

  localparam int BIT_W = $clog2(`HL_SPI_W);
  localparam int REL_W = $clog2(`HL_RST_RELEASE_CYCLES + 1);

  logic                 active_q;
  logic                 sclk_q;
  logic [BIT_W-1:0]     bit_cnt_q;
  logic [`HL_SPI_W-1:0] shift_q;
  logic [REL_W-1:0]     rel_cnt_q;
  logic                 last_bit;

  assign busy_o  = active_q;
  assign sen_n_o = ~active_q;
  assign sclk_o  = sclk_q;
  // MSB first
  assign sdio_o  = shift_q[`HL_SPI_W-1];

  // Falling sclk after the final bit closes the frame
  assign last_bit = sclk_q && (bit_cnt_q == BIT_W'(`HL_SPI_W - 1));

  ////////////////////////////////////////
  // Serial frame
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      active_q  <= 1'b0;
      sclk_q    <= 1'b0;
      bit_cnt_q <= '0;
    end else if (!active_q) begin
      sclk_q <= 1'b0;
      if (start_i) begin
        active_q  <= 1'b1;
        bit_cnt_q <= '0;
      end
    end else begin
      // Half rate clock, low first
      sclk_q <= ~sclk_q;
      if (sclk_q) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (last_bit) begin
        active_q <= 1'b0;
        sclk_q   <= 1'b0;
      end
    end
  end

  // Data moves only on falling sclk, so it holds through the high phase
  always_ff @(posedge clk_ctrl) begin
    if (!active_q && start_i) begin
      shift_q <= word_i;
    end else if (active_q && sclk_q) begin
      shift_q <= {shift_q[`HL_SPI_W-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////
  // Chip reset release
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      rel_cnt_q <= '0;
    end else if (rel_cnt_q != REL_W'(`HL_RST_RELEASE_CYCLES)) begin
      rel_cnt_q <= rel_cnt_q + 1'b1;
    end
  end

  assign ad9866_rst_n_o = (rel_cnt_q == REL_W'(`HL_RST_RELEASE_CYCLES));

endmodule

//--- ctrl_regs.sv
`timescale 1ns/1ns
`include "hl_ctrl_macros.svh"

module ctrl_regs (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,
  input  logic                  cmd_rqst_i,
  input  logic                  spi_busy_i,
  input  hl_ctrl_pkg::cmd_t     cmd_i,
  input  hl_ctrl_pkg::rx_flags_t  rx_flags_i,
  input  hl_ctrl_pkg::net_state_t net_state_i,
  output logic                  tx_on_o,
  output logic                  cw_keydown_o,
  output logic                  tx_hang_o,
  output logic                  spi_start_o,
  output logic                  resp_valid_o,
  output logic [`HL_SPI_W-1:0]  spi_word_o,
  output logic [`HL_RESP_W-1:0] resp_o
);

  localparam int HANG_W = $clog2(`HL_TX_HANG_CYCLES + 1);

  logic                  wr_tx_ctrl;
  logic                  wr_spi;
  logic                  resp_req;
  logic                  tx_on_d;
  logic [HANG_W-1:0]     hang_cnt_q;
  logic [HANG_W-1:0]     hang_cnt_d;
  logic                  clip_q;
  logic                  good_q;
  logic [`HL_RESP_W-1:0] resp_d;

  // Command decode
  assign wr_tx_ctrl = cmd_rqst_i && (cmd_i.addr == `HL_REG_TX_CTRL);
  assign wr_spi     = cmd_rqst_i && (cmd_i.addr == `HL_REG_AD9866_SPI);
  assign resp_req   = cmd_rqst_i && cmd_i.requires_resp;

  // Every command carries the ptt state
  assign tx_on_d   = cmd_rqst_i ? cmd_i.ptt : tx_on_o;
  assign tx_hang_o = (hang_cnt_q != '0);

  ////////////////////////////////////////
  // Hang timer
  ////////////////////////////////////////

  always_comb begin
    hang_cnt_d = hang_cnt_q;
    if (tx_on_d) begin
      hang_cnt_d = '0;
    end else if (tx_on_o) begin
      // Transmit ends this cycle
      hang_cnt_d = HANG_W'(`HL_TX_HANG_CYCLES);
    end else if (hang_cnt_q != '0) begin
      hang_cnt_d = hang_cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Response word
  ////////////////////////////////////////

  always_comb begin
    resp_d = '0;
    resp_d[`HL_RESP_ADDR_LSB +: `HL_CMD_ADDR_W] = cmd_i.addr;
    resp_d[`HL_RESP_TXON_BIT]   = tx_on_d;
    resp_d[`HL_RESP_HANG_BIT]   = (hang_cnt_d != '0);
    // Include a level that arrives right on the capture edge
    resp_d[`HL_RESP_CLIP_BIT]   = clip_q | rx_flags_i.clip;
    resp_d[`HL_RESP_GOOD_BIT]   = good_q | rx_flags_i.goodlvl;
    resp_d[`HL_RESP_SPEED_LSB +: 2] = net_state_i.speed;
    resp_d[`HL_RESP_HAVEIP_BIT] = net_state_i.dhcp | net_state_i.fixedip;
    resp_d[`HL_RESP_BUSY_BIT]   = spi_busy_i;
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      tx_on_o      <= 1'b0;
      cw_keydown_o <= 1'b0;
      hang_cnt_q   <= '0;
      spi_start_o  <= 1'b0;
      resp_valid_o <= 1'b0;
      clip_q       <= 1'b0;
      good_q       <= 1'b0;
    end else begin
      tx_on_o      <= tx_on_d;
      hang_cnt_q   <= hang_cnt_d;
      spi_start_o  <= wr_spi;
      resp_valid_o <= resp_req;
      if (wr_tx_ctrl) begin
        cw_keydown_o <= cmd_i.data[0];
      end
      // Sticky until reported, a new set beats the clear
      clip_q <= rx_flags_i.clip | (clip_q & ~resp_valid_o);
      good_q <= rx_flags_i.goodlvl | (good_q & ~resp_valid_o);
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (wr_spi) begin
      spi_word_o <= cmd_i.data[`HL_SPI_W-1:0];
    end
    if (resp_req) begin
      resp_o <= resp_d;
    end
  end

endmodule

//--- hl_ctrl_top.sv
`timescale 1ns/1ns
`include "hl_ctrl_macros.svh"

module hl_ctrl_top (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  logic                      cmd_cnt_i,
  input  logic                      cmd_ptt_i,
  input  logic                      cmd_resp_i,
  input  logic                      rxclip_i,
  input  logic                      rxgoodlvl_i,
  input  logic                      net_dhcp_i,
  input  logic                      net_fixedip_i,
  input  logic [`HL_CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [`HL_CMD_DATA_W-1:0] cmd_data_i,
  input  logic [1:0]                net_speed_i,
  output logic                      tx_on_o,
  output logic                      cw_keydown_o,
  output logic                      tx_hang_o,
  output logic                      resp_valid_o,
  output logic                      ad9866_rst_n_o,
  output logic                      ad9866_sen_n_o,
  output logic                      ad9866_sclk_o,
  output logic                      ad9866_sdio_o,
  output logic [`HL_RESP_W-1:0]     resp_o
);

  logic                    cmd_rqst;
  hl_ctrl_pkg::cmd_t       cmd;
  logic                    spi_start;
  logic [`HL_SPI_W-1:0]    spi_word;
  logic                    spi_busy;
  hl_ctrl_pkg::rx_flags_t  rx_flags_s;
  hl_ctrl_pkg::net_state_t net_state_s;

  ////////////////////////////////////////
  // Crossings into clk_ctrl
  ////////////////////////////////////////

  cmd_capture u_cmd_capture (
    .clk_ctrl   (clk_ctrl),
    .rst_n_i    (rst_n_i),
    .cmd_cnt_i  (cmd_cnt_i),
    .cmd_ptt_i  (cmd_ptt_i),
    .cmd_resp_i (cmd_resp_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .cmd_rqst_o (cmd_rqst),
    .cmd_o      (cmd)
  );

  // Field order follows rx_flags_t
  level_sync #(
    .T      (hl_ctrl_pkg::rx_flags_t),
    .STAGES (`HL_SYNC_STAGES)
  ) u_rx_sync (
    .clk_ctrl (clk_ctrl),
    .rst_n_i  (rst_n_i),
    .d_i      ({rxclip_i, rxgoodlvl_i}),
    .q_o      (rx_flags_s)
  );

  level_sync #(
    .T      (hl_ctrl_pkg::net_state_t),
    .STAGES (`HL_SYNC_STAGES)
  ) u_net_sync (
    .clk_ctrl (clk_ctrl),
    .rst_n_i  (rst_n_i),
    .d_i      ({net_dhcp_i, net_fixedip_i, net_speed_i}),
    .q_o      (net_state_s)
  );

  ////////////////////////////////////////
  // Control and front-end serial port
  ////////////////////////////////////////

  ctrl_regs u_ctrl_regs (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .cmd_rqst_i   (cmd_rqst),
    .spi_busy_i   (spi_busy),
    .cmd_i        (cmd),
    .rx_flags_i   (rx_flags_s),
    .net_state_i  (net_state_s),
    .tx_on_o      (tx_on_o),
    .cw_keydown_o (cw_keydown_o),
    .tx_hang_o    (tx_hang_o),
    .spi_start_o  (spi_start),
    .resp_valid_o (resp_valid_o),
    .spi_word_o   (spi_word),
    .resp_o       (resp_o)
  );

  ad9866_spi u_ad9866_spi (
    .clk_ctrl       (clk_ctrl),
    .rst_n_i        (rst_n_i),
    .start_i        (spi_start),
    .word_i         (spi_word),
    .busy_o         (spi_busy),
    .sen_n_o        (ad9866_sen_n_o),
    .sclk_o         (ad9866_sclk_o),
    .sdio_o         (ad9866_sdio_o),
    .ad9866_rst_n_o (ad9866_rst_n_o)
  );

endmodule

//--- hl_ctrl_sva.sv
`timescale 1ns/1ns
`include "hl_ctrl_macros.svh"

module hl_ctrl_sva (
  input logic                      clk_ctrl,
  input logic                      rst_n_i,
  input logic                      cmd_cnt_i,
  input logic                      cmd_ptt_i,
  input logic                      cmd_resp_i,
  input logic                      rxclip_i,
  input logic                      rxgoodlvl_i,
  input logic                      net_dhcp_i,
  input logic                      net_fixedip_i,
  input logic [`HL_CMD_ADDR_W-1:0] cmd_addr_i,
  input logic [`HL_CMD_DATA_W-1:0] cmd_data_i,
  input logic [1:0]                net_speed_i,
  input logic                      tx_on_o,
  input logic                      cw_keydown_o,
  input logic                      tx_hang_o,
  input logic                      resp_valid_o,
  input logic                      ad9866_rst_n_o,
  input logic                      ad9866_sen_n_o,
  input logic                      ad9866_sclk_o,
  input logic                      ad9866_sdio_o,
  input logic [`HL_RESP_W-1:0]     resp_o
);

  int                        err_cnt = 0;
  logic                      in_rst_q;
  logic                      busy_prev_q;
  logic                      cnt_q;
  logic                      tog;
  logic [3:0]                resp_pipe_q;
  logic [`HL_CMD_ADDR_W-1:0] shadow_addr;
  logic [`HL_CMD_DATA_W-1:0] shadow_data;
  logic                      shadow_ptt;
  logic [`HL_SPI_W-1:0]      col_word;
  int                        col_cnt;
  int                        hang_run;
  int                        clip_run;
  int                        good_run;
  logic                      clip_seen;
  logic                      clip_any;
  logic                      good_seen;
  logic                      good_any;

  // A new count level seen on this edge
  assign tog = (cmd_cnt_i != cnt_q);

  ////////////////////////////////////////
  // Shadow state and serial collector
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    in_rst_q    <= !rst_n_i;
    // Frame in progress when the response word is formed
    busy_prev_q <= !ad9866_sen_n_o;
    if (!rst_n_i) begin
      cnt_q       <= 1'b0;
      resp_pipe_q <= '0;
      col_cnt     <= 0;
      hang_run    <= 0;
      clip_run    <= 0;
      good_run    <= 0;
      clip_seen   <= 1'b0;
      clip_any    <= 1'b0;
      good_seen   <= 1'b0;
      good_any    <= 1'b0;
    end else begin
      cnt_q       <= cmd_cnt_i;
      resp_pipe_q <= {resp_pipe_q[2:0], tog && cmd_resp_i};
      if (tog) begin
        shadow_addr <= cmd_addr_i;
        shadow_data <= cmd_data_i;
        shadow_ptt  <= cmd_ptt_i;
      end
      if (ad9866_sen_n_o) begin
        col_cnt <= 0;
      end else if (ad9866_sclk_o) begin
        col_word <= {col_word[`HL_SPI_W-2:0], ad9866_sdio_o};
        col_cnt  <= col_cnt + 1;
      end
      hang_run  <= (tx_hang_o && !tx_on_o) ? hang_run + 1 : 0;
      clip_run  <= rxclip_i ? clip_run + 1 : 0;
      good_run  <= rxgoodlvl_i ? good_run + 1 : 0;
      // Six high samples in a row count as a sure set
      clip_seen <= (rxclip_i && clip_run >= 5) | (clip_seen & ~resp_valid_o);
      clip_any  <= rxclip_i | (clip_any & ~resp_valid_o);
      good_seen <= (rxgoodlvl_i && good_run >= 5) | (good_seen & ~resp_valid_o);
      good_any  <= rxgoodlvl_i | (good_any & ~resp_valid_o);
    end
  end

  ////////////////////////////////////////
  // Reset state
  ////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk_ctrl) in_rst_q |->
      (!tx_on_o && !cw_keydown_o && !tx_hang_o && !resp_valid_o &&
       ad9866_sen_n_o && !ad9866_sclk_o && !ad9866_rst_n_o))
    else begin err_cnt++; $error("Outputs not idle during or right after reset"); end

  a_rst_release: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      in_rst_q |-> (!ad9866_rst_n_o)[*`HL_RST_RELEASE_CYCLES] ##1 ad9866_rst_n_o)
    else begin err_cnt++; $error("AD9866 reset not released after the release time"); end

  ////////////////////////////////////////
  // Transmit and hang
  ////////////////////////////////////////

  a_tx_on: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      tog |-> ##4 (tx_on_o == shadow_ptt))
    else begin
      err_cnt++;
      $error("[FAIL] tx_on: expected %0b, actual %0b", $sampled(shadow_ptt),
             $sampled(tx_on_o));
    end

  a_cw_key: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      tog && (cmd_addr_i == `HL_REG_TX_CTRL) |-> ##4 (cw_keydown_o == shadow_data[0]))
    else begin
      err_cnt++;
      $error("[FAIL] cw_keydown: expected %0b, actual %0b", $sampled(shadow_data[0]),
             $sampled(cw_keydown_o));
    end

  a_hang_start: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      $fell(tx_on_o) |-> tx_hang_o)
    else begin err_cnt++; $error("Hang did not start when transmit ended"); end

  a_hang_excl: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      tx_on_o |-> !tx_hang_o)
    else begin err_cnt++; $error("Hang high while transmitting"); end

  a_hang_max: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      tx_hang_o |-> (hang_run < `HL_TX_HANG_CYCLES))
    else begin err_cnt++; $error("Hang lasted longer than the hang time"); end

  a_hang_len: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      $fell(tx_hang_o) && !tx_on_o |-> (hang_run == `HL_TX_HANG_CYCLES))
    else begin
      err_cnt++;
      $error("[FAIL] hang_len: expected %0d, actual %0d", `HL_TX_HANG_CYCLES,
             $sampled(hang_run));
    end

  ////////////////////////////////////////
  // AD9866 serial write
  ////////////////////////////////////////

  a_spi_frame: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      tog && (cmd_addr_i == `HL_REG_AD9866_SPI) |->
      ##4 ad9866_sen_n_o ##1 (!ad9866_sen_n_o)[*(2*`HL_SPI_W)] ##1 ad9866_sen_n_o)
    else begin err_cnt++; $error("AD9866 enable frame has the wrong length"); end

  a_spi_word: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      $rose(ad9866_sen_n_o) |->
      (col_word == shadow_data[`HL_SPI_W-1:0]) && (col_cnt == `HL_SPI_W))
    else begin
      err_cnt++;
      $error("[FAIL] spi_word: expected %h, actual %h", $sampled(shadow_data[15:0]),
             $sampled(col_word));
    end

  a_sdio_stable: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      $rose(ad9866_sclk_o) |-> $stable(ad9866_sdio_o) && !ad9866_sen_n_o)
    else begin err_cnt++; $error("Serial data moved while the clock was high"); end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  a_resp_when: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      resp_valid_o == resp_pipe_q[3])
    else begin
      err_cnt++;
      $error("[FAIL] resp_valid: expected %0b, actual %0b", $sampled(resp_pipe_q[3]),
             $sampled(resp_valid_o));
    end

  a_resp_fields: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      resp_valid_o |->
      (resp_o[`HL_RESP_ADDR_LSB +: `HL_CMD_ADDR_W] == shadow_addr) &&
      (resp_o[`HL_RESP_TXON_BIT] == shadow_ptt) &&
      (resp_o[`HL_RESP_HANG_BIT] == tx_hang_o) &&
      (resp_o[`HL_RESP_SPEED_LSB +: 2] == net_speed_i) &&
      (resp_o[`HL_RESP_HAVEIP_BIT] == (net_dhcp_i | net_fixedip_i)) &&
      (resp_o[`HL_RESP_BUSY_BIT] == busy_prev_q) &&
      (resp_o[31:6] == '0))
    else begin
      err_cnt++;
      $error("[FAIL] resp_fields: expected addr %h ptt %0b busy %0b, actual %h",
             $sampled(shadow_addr), $sampled(shadow_ptt), $sampled(busy_prev_q),
             $sampled(resp_o));
    end

  a_clip_flag: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      resp_valid_o |-> (!clip_seen || resp_o[`HL_RESP_CLIP_BIT]) &&
                       (clip_any || !resp_o[`HL_RESP_CLIP_BIT]))
    else begin
      err_cnt++;
      $error("[FAIL] clip_flag: expected %0b, actual %0b", $sampled(clip_seen),
             $sampled(resp_o[0]));
    end

  a_good_flag: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
      resp_valid_o |-> (!good_seen || resp_o[`HL_RESP_GOOD_BIT]) &&
                       (good_any || !resp_o[`HL_RESP_GOOD_BIT]))
    else begin
      err_cnt++;
      $error("[FAIL] good_flag: expected %0b, actual %0b", $sampled(good_seen),
             $sampled(resp_o[1]));
    end

endmodule

bind hl_ctrl_top hl_ctrl_sva u_sva (.*);

//--- tb_hl_ctrl.sv
`timescale 1ns/1ns
`include "hl_ctrl_macros.svh"

module tb_hl_ctrl;

  localparam int SIG_RESP  = 0;
  localparam int SIG_SEN   = 1;
  localparam int SIG_HANG  = 2;
  localparam int SIG_ADRST = 3;

  logic                      clk_ctrl;
  logic                      rst_n_i;
  logic                      cmd_cnt_i;
  logic                      cmd_ptt_i;
  logic                      cmd_resp_i;
  logic                      rxclip_i;
  logic                      rxgoodlvl_i;
  logic                      net_dhcp_i;
  logic                      net_fixedip_i;
  logic [`HL_CMD_ADDR_W-1:0] cmd_addr_i;
  logic [`HL_CMD_DATA_W-1:0] cmd_data_i;
  logic [1:0]                net_speed_i;
  logic                      tx_on_o;
  logic                      cw_keydown_o;
  logic                      tx_hang_o;
  logic                      resp_valid_o;
  logic                      ad9866_rst_n_o;
  logic                      ad9866_sen_n_o;
  logic                      ad9866_sclk_o;
  logic                      ad9866_sdio_o;
  logic [`HL_RESP_W-1:0]     resp_o;
  logic [15:0]               lfsr_q;

  initial clk_ctrl = 1'b0;
  always #4 clk_ctrl = ~clk_ctrl;

  hl_ctrl_top UUT (.*);

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  // Any assertion failure ends the run
  always @(negedge clk_ctrl) begin
    if (UUT.u_sva.err_cnt != 0) begin
      fail_stop("An assertion reported an error");
    end
  end

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] get_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SIG_RESP: return resp_valid_o;
      SIG_SEN:  return ad9866_sen_n_o;
      SIG_HANG: return tx_hang_o;
      default:  return ad9866_rst_n_o;
    endcase
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_ctrl);
      #1;
    end
  endtask

  task automatic wait_for(input int sel, input logic val, input int limit,
                          input string what);
    int n;
    n = 0;
    while (probe(sel) !== val) begin
      @(posedge clk_ctrl);
      #1;
      n++;
      if (n > limit) begin
        fail_stop({"Timeout while waiting for ", what});
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [5:0]  addr;
    logic        want_resp;
    lfsr_q        = 16'd7220;
    rst_n_i       = 1'b0;
    cmd_cnt_i     = 1'b0;
    cmd_ptt_i     = 1'b0;
    cmd_resp_i    = 1'b0;
    cmd_addr_i    = '0;
    cmd_data_i    = '0;
    rxclip_i      = 1'b0;
    rxgoodlvl_i   = 1'b0;
    net_dhcp_i    = 1'b0;
    net_fixedip_i = 1'b0;
    net_speed_i   = 2'b00;
    repeat (16) @(posedge clk_ctrl);
    #1;
    rst_n_i = 1'b1;
    wait_for(SIG_ADRST, 1'b1, `HL_RST_RELEASE_CYCLES + 4, "AD9866 reset release");

    for (int k = 0; k < 48; k++) begin
      // Status levels settle before the command
      r = get_bits(2);
      rxclip_i = r[0] & r[1];
      r = get_bits(2);
      rxgoodlvl_i = r[0] & r[1];
      r = get_bits(4);
      {net_dhcp_i, net_fixedip_i, net_speed_i} = r[3:0];
      idle(10);

      r = get_bits(2);
      case (r[1:0])
        2'd0:    addr = `HL_REG_TX_CTRL;
        2'd1:    addr = `HL_REG_AD9866_SPI;
        default: begin
          r = get_bits(6);
          addr = r[5:0];
        end
      endcase
      r = get_bits(32);
      cmd_data_i = r;
      r = get_bits(1);
      cmd_ptt_i = r[0];
      r = get_bits(2);
      want_resp  = (r[1:0] != 2'b00);
      cmd_resp_i = want_resp;
      cmd_addr_i = addr;
      cmd_cnt_i  = ~cmd_cnt_i;

      if (want_resp) begin
        wait_for(SIG_RESP, 1'b1, 12, "response pulse");
      end
      if (addr == `HL_REG_AD9866_SPI) begin
        wait_for(SIG_SEN, 1'b0, 12, "AD9866 frame start");
        wait_for(SIG_SEN, 1'b1, 2 * `HL_SPI_W + 4, "AD9866 frame end");
      end
      idle(10);
      // Sometimes let the hang run out, sometimes cut it short
      if (tx_hang_o) begin
        r = get_bits(1);
        if (r[0]) begin
          wait_for(SIG_HANG, 1'b0, `HL_TX_HANG_CYCLES + 4, "end of hang");
        end
      end
    end

    idle(10);
    if (UUT.u_sva.err_cnt == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      fail_stop("Assertion errors were counted during the run");
    end
  end

endmodule

//--- hl_ctrl.f
+incdir+.
hl_ctrl_pkg.sv
level_sync.sv
cmd_capture.sv
ad9866_spi.sv
ctrl_regs.sv
hl_ctrl_top.sv
hl_ctrl_sva.sv
tb_hl_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_hl_ctrl
FILELIST  := hl_ctrl.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal --top-module $(TOP)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)
RUNFLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
